// File: hw/fifo_defs.svh
`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

// ************************************************************************
// read-data buffer geometry
// ************************************************************************

`define FIFO_DEPTH_W      4     // address bits, 16 entries
`define FIFO_DATA_W       32    // one bus word

// ************************************************************************
// water-level thresholds
// ************************************************************************

// compared against the registered levels on each side
`define FIFO_ALMOST_FULL  14    // write level at or above
`define FIFO_ALMOST_EMPTY 2     // read level at or below

`endif

// File: hw/fifo_pkg.sv
`include "fifo_defs.svh"

package fifo_pkg;

    // pointer carries one extra wrap bit above the address
    // same width serves binary and gray form
    typedef logic [`FIFO_DEPTH_W:0]   ptr_t;

    // storage index into the dual-port array
    typedef logic [`FIFO_DEPTH_W-1:0] addr_t;

    // fill count, 0 up to full depth inclusive
    typedef logic [`FIFO_DEPTH_W:0]   level_t;

    // payload word from the bus slave
    typedef logic [`FIFO_DATA_W-1:0]  data_t;

    // helper for the pointer registers
    function automatic ptr_t bin2gray(input ptr_t bin);
        ptr_t gray;
        gray = bin ^ (bin >> 1);    // neighbour xor
        return gray;
    endfunction

endpackage

// File: hw/gray_sync.sv
module gray_sync #(
    parameter int STAGES = 2            // flops in the destination domain
) (
    input  logic           clk,         // destination clock
    input  logic           rst,         // destination reset, async high
    input  fifo_pkg::ptr_t gray_in,     // registered gray pointer, other domain
    output fifo_pkg::ptr_t bin_out      // binary pointer, destination domain
);

    import fifo_pkg::*;

    ptr_t sync_q [STAGES];              // synchronizer chain
    ptr_t gray_s;                       // last stage

    // ************************************************************************
    // sampling chain
    // ************************************************************************

    // one bit moves per source edge, so any sample is the old or new pointer
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sync_q <= '{default: '0};
        end
        else
        begin
            sync_q[0] <= gray_in;       // first stage, may go metastable
            for (int i = 1; i < STAGES; i++)
            begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign gray_s = sync_q[STAGES-1];

    // gray to binary by xor-fold of all bits at and above each position
    always_comb
    begin
        for (int i = 0; i < $bits(ptr_t); i++)
        begin
            bin_out[i] = ^(gray_s >> i);
        end
    end

endmodule

// File: hw/fifo_ctrl.sv
`include "fifo_defs.svh"

module fifo_ctrl (
    // write domain
    input  logic             wclk,
    input  logic             wrst,
    input  logic             w_en,              // push strobe
    output logic             wr_go,             // accepted write to storage
    output fifo_pkg::addr_t  waddr,
    output logic             wfull,
    output logic             almost_full,
    output fifo_pkg::level_t wr_water_level,

    // read domain
    input  logic             rclk,
    input  logic             rrst,
    input  logic             r_en,              // pop strobe
    output logic             rd_go,             // accepted read to storage
    output fifo_pkg::addr_t  raddr,
    output logic             rempty,
    output logic             almost_empty,
    output fifo_pkg::level_t rd_water_level
);

    import fifo_pkg::*;

    localparam int AW = `FIFO_DEPTH_W;          // address bits, wrap bit is AW

    // write side pointers
    ptr_t wbin;                                 // current binary write pointer
    ptr_t wgray;                                // registered gray, goes to rclk
    ptr_t wbnext;                               // next binary
    ptr_t wgnext;                               // next gray
    ptr_t wq_rptr;                              // read pointer seen on wclk

    // read side pointers
    ptr_t rbin;                                 // current binary read pointer
    ptr_t rgray;                                // registered gray, goes to wclk
    ptr_t rbnext;
    ptr_t rgnext;
    ptr_t rq_wptr;                              // write pointer seen on rclk

    // ************************************************************************
    // write domain
    // ************************************************************************

    assign wr_go  = w_en & ~wfull;              // drop pushes while full
    assign wbnext = wbin + ptr_t'(wr_go);
    assign wgnext = bin2gray(wbnext);
    assign waddr  = wbin[AW-1:0];               // storage index, wrap bit off

    always_ff @(posedge wclk or posedge wrst)
    begin
        if (wrst)
        begin
            wbin  <= '0;
            wgray <= '0;
        end
        else
        begin
            wbin  <= wbnext;
            wgray <= wgnext;                    // only registered gray crosses
        end
    end

    // full when one lap ahead of the synced read pointer
    always_ff @(posedge wclk or posedge wrst)
    begin
        if (wrst)
        begin
            wfull <= 1'b0;
        end
        else
        begin
            wfull <= (wbnext[AW] != wq_rptr[AW]) &&
                     (wbnext[AW-1:0] == wq_rptr[AW-1:0]);
        end
    end

    // level from next pointer, modulo arithmetic handles the wrap
    always_ff @(posedge wclk or posedge wrst)
    begin
        if (wrst)
        begin
            wr_water_level <= '0;
        end
        else
        begin
            wr_water_level <= level_t'(wbnext - wq_rptr);
        end
    end

    assign almost_full = (wr_water_level >= level_t'(`FIFO_ALMOST_FULL));

    // read pointer into write domain
    gray_sync u_r2w (
        .clk     (wclk),
        .rst     (wrst),
        .gray_in (rgray),
        .bin_out (wq_rptr)
    );

    // ************************************************************************
    // read domain
    // ************************************************************************

    assign rd_go  = r_en & ~rempty;             // drop pops while empty
    assign rbnext = rbin + ptr_t'(rd_go);
    assign rgnext = bin2gray(rbnext);
    assign raddr  = rbin[AW-1:0];

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            rbin  <= '0;
            rgray <= '0;
        end
        else
        begin
            rbin  <= rbnext;
            rgray <= rgnext;
        end
    end

    // empty as soon as the next read catches the synced write pointer
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            rempty <= 1'b1;
        end
        else
        begin
            rempty <= (rbnext == rq_wptr);
        end
    end

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            rd_water_level <= '0;
        end
        else
        begin
            rd_water_level <= level_t'(rq_wptr - rbnext);   // words left to pop
        end
    end

    assign almost_empty = (rd_water_level <= level_t'(`FIFO_ALMOST_EMPTY));

    // write pointer into read domain
    gray_sync u_w2r (
        .clk     (rclk),
        .rst     (rrst),
        .gray_in (wgray),
        .bin_out (rq_wptr)
    );

endmodule

// File: hw/fifo_ram.sv
`include "fifo_defs.svh"

module fifo_ram (
    // write port
    input  logic            wclk,
    input  logic            wr_go,          // write already qualified by wfull
    input  fifo_pkg::addr_t waddr,
    input  fifo_pkg::data_t wdata,

    // read port
    input  logic            rclk,
    input  logic            rd_go,          // read already qualified by rempty
    input  fifo_pkg::addr_t raddr,
    output fifo_pkg::data_t rdata           // registered output
);

    import fifo_pkg::*;

    localparam int DEPTH = 1 << `FIFO_DEPTH_W;

    data_t mem [DEPTH];                     // maps to block ram

    // write on wclk
    always_ff @(posedge wclk)
    begin
        if (wr_go)
        begin
            mem[waddr] <= wdata;
        end
    end

    // output register holds last word between reads
    always_ff @(posedge rclk)
    begin
        if (rd_go)
        begin
            rdata <= mem[raddr];
        end
    end

endmodule

// File: hw/rd_data_fifo.sv
module rd_data_fifo (
    // write side, producer
    input  logic             wclk,
    input  logic             wrst,
    input  logic             w_en,
    input  fifo_pkg::data_t  wdata,
    output logic             wfull,
    output logic             almost_full,
    output fifo_pkg::level_t wr_water_level,

    // read side, bus slave
    input  logic             rclk,
    input  logic             rrst,
    input  logic             r_en,
    output fifo_pkg::data_t  rdata,
    output logic             rdata_valid,      // one cycle after accepted pop
    output logic             rempty,
    output logic             almost_empty,
    output fifo_pkg::level_t rd_water_level
);

    import fifo_pkg::*;

    logic  wr_go;                               // qualified push
    addr_t waddr;
    logic  rd_go;                               // qualified pop
    addr_t raddr;

    // ************************************************************************
    // pointers and flags
    // ************************************************************************

    fifo_ctrl u_ctrl (
        .wclk           (wclk),
        .wrst           (wrst),
        .w_en           (w_en),
        .wr_go          (wr_go),
        .waddr          (waddr),
        .wfull          (wfull),
        .almost_full    (almost_full),
        .wr_water_level (wr_water_level),
        .rclk           (rclk),
        .rrst           (rrst),
        .r_en           (r_en),
        .rd_go          (rd_go),
        .raddr          (raddr),
        .rempty         (rempty),
        .almost_empty   (almost_empty),
        .rd_water_level (rd_water_level)
    );

    // storage, read register lines up with rdata_valid
    fifo_ram u_ram (
        .wclk  (wclk),
        .wr_go (wr_go),
        .waddr (waddr),
        .wdata (wdata),
        .rclk  (rclk),
        .rd_go (rd_go),
        .raddr (raddr),
        .rdata (rdata)
    );

    // valid follows the ram output register by construction
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
            rdata_valid <= 1'b0;
        else
            rdata_valid <= rd_go;               // high for one rclk only
    end

endmodule

// File: dv/tb_clk_gen.sv
module tb_clk_gen #(
    parameter int PERIOD_NS  = 100,     // full clock period
    parameter int RST_CYCLES = 8        // reset length in own cycles
) (
    output logic clk,
    output logic rst                    // async high, released on a falling edge
);

    timeunit 1ns;
    timeprecision 1ps;

    // free running clock, starts low
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // reset held for the first cycles of this domain
    initial
    begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;                     // away from the active edge
    end

endmodule

// File: dv/tb_rd_data_fifo.sv
`include "fifo_defs.svh"

module tb_rd_data_fifo;

    timeunit 1ns;
    timeprecision 1ps;

    import fifo_pkg::*;

    localparam int RCLK_NS        = 100;         // read side bus slave
    localparam int WCLK_NS        = 70;          // write side producer
    localparam int RST_CYC        = 8;
    localparam int SEED           = 32'h189e;
    localparam int TIMEOUT_MARGIN = 64;          // rclk cycles on top of the vectors
    localparam int SETTLE_CYC     = 8;           // bound on one crossing in own cycles
    localparam int VEC_MAX        = 64;
    localparam int DEPTH          = 1 << `FIFO_DEPTH_W;

    logic   wclk, wrst, rclk, rrst;
    logic   w_en, r_en;
    data_t  wdata, rdata;
    logic   rdata_valid;
    logic   wfull, almost_full, rempty, almost_empty;
    level_t wr_water_level, rd_water_level;

    logic [43:0] vec_mem [VEC_MAX];             // one packed vector per line
    data_t       model_q [$];                   // words written but not yet seen
    logic        pend;                          // pop accepted and data due next tick
    int          cycles      = 0;
    int          cycle_limit = 0;               // 0 until vectors are sized
    int          n_vec;
    int          total;
    logic        found_end;

    tb_clk_gen #(.PERIOD_NS(RCLK_NS), .RST_CYCLES(RST_CYC)) u_rclk_gen (
        .clk (rclk),
        .rst (rrst)
    );

    tb_clk_gen #(.PERIOD_NS(WCLK_NS), .RST_CYCLES(RST_CYC)) u_wclk_gen (
        .clk (wclk),
        .rst (wrst)
    );

    rd_data_fifo u_dut (
        .wclk           (wclk),
        .wrst           (wrst),
        .w_en           (w_en),
        .wdata          (wdata),
        .wfull          (wfull),
        .almost_full    (almost_full),
        .wr_water_level (wr_water_level),
        .rclk           (rclk),
        .rrst           (rrst),
        .r_en           (r_en),
        .rdata          (rdata),
        .rdata_valid    (rdata_valid),
        .rempty         (rempty),
        .almost_empty   (almost_empty),
        .rd_water_level (rd_water_level)
    );

    // ************************************************************************
    // failure and compare
    // ************************************************************************

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp)
        begin
            abort_run($sformatf("ERROR %s got %h exp %h", name, got, exp));
        end
    endtask

    // ************************************************************************
    // per-domain ticks driven on the falling edge
    // ************************************************************************

    // one wclk cycle that pushes into the model only while it has room
    task automatic wtick(input logic wr);
        @(negedge wclk);
        w_en = wr;
        if (wr)
        begin
            check_val("wfull", wfull, model_q.size() == DEPTH);
            wdata = $urandom();
            if (model_q.size() < DEPTH)
            begin
                model_q.push_back(wdata);
            end
        end
    endtask

    // one rclk cycle that checks the data of the last accepted pop
    task automatic rtick(input logic rd);
        @(negedge rclk);
        check_val("rdata_valid", rdata_valid, pend);
        if (pend)
        begin
            check_val("rdata", rdata, model_q[0]);
            void'(model_q.pop_front());
        end
        r_en = rd;
        if (rd)
        begin
            check_val("rempty", rempty, model_q.size() == 0);
        end
        pend = rd && (model_q.size() != 0);     // accepted on the coming edge
    endtask

    // read side first since its level only climbs toward the model
    // each side waits a bounded number of its own cycles for the crossing
    task automatic settle();
        int n;
        n = 0;
        do
        begin
            rtick(1'b0);
            n++;
        end
        while ((pend || rd_water_level != level_t'(model_q.size())) && n < SETTLE_CYC);
        n = 0;
        do
        begin
            wtick(1'b0);
            n++;
        end
        while (wr_water_level != level_t'(model_q.size()) && n < SETTLE_CYC);
    endtask

    // flags and levels after the crossing has settled
    task automatic check_state(input logic [43:0] v);
        level_t lvl;
        lvl = level_t'(model_q.size());
        check_val("wfull", wfull, v[31:28]);
        check_val("rempty", rempty, v[27:24]);
        check_val("almost_full", almost_full, v[23:20]);
        check_val("almost_empty", almost_empty, v[19:16]);
        check_val("wr_water_level", wr_water_level, v[15:8]);
        check_val("rd_water_level", rd_water_level, v[7:0]);
        check_val("wr_water_level", wr_water_level, lvl);   // model agrees too
        check_val("rd_water_level", rd_water_level, lvl);
        check_val("almost_full", almost_full, lvl >= `FIFO_ALMOST_FULL);
        check_val("almost_empty", almost_empty, lvl <= `FIFO_ALMOST_EMPTY);
        check_val("wfull", wfull, lvl == DEPTH);
        check_val("rempty", rempty, lvl == 0);
        check_val("rdata_valid", rdata_valid, 1'b0);
    endtask

    task automatic run_vector(input logic [43:0] v);
        case (v[43:40])
            4'h0:                               // idle
            begin
                repeat (v[39:32]) rtick(1'b0);
            end
            4'h1:                               // write burst
            begin
                repeat (v[39:32]) wtick(1'b1);
                wtick(1'b0);
            end
            4'h2:                               // read burst
            begin
                repeat (v[39:32]) rtick(1'b1);
                rtick(1'b0);
            end
            default:
            begin
                abort_run($sformatf("unknown operation code %h in vector file", v[43:40]));
            end
        endcase
        settle();
        check_state(v);
    endtask

    // ************************************************************************
    // timeout counted in rclk
    // ************************************************************************

    always @(posedge rclk)
    begin
        cycles++;
        if (cycle_limit != 0 && cycles > cycle_limit)
        begin
            abort_run($sformatf("timeout after %0d rclk cycles, DUT did not settle",
                                cycles));
        end
    end

    // ************************************************************************
    // main sequence
    // ************************************************************************

    initial
    begin
        w_en  = 1'b0;
        wdata = '0;
        r_en  = 1'b0;
        pend  = 1'b0;
        void'($urandom(SEED));                  // write data stream
        $readmemh("dv/rd_fifo_vectors.txt", vec_mem);

        // count vectors up to the end marker and size the timeout
        n_vec     = 0;
        total     = 0;
        found_end = 1'b0;
        for (int i = 0; i < VEC_MAX && !found_end; i++)
        begin
            if ($isunknown(vec_mem[i]))
            begin
                abort_run("vector file ran out before the end marker");
            end
            else if (vec_mem[i][43:40] == 4'hf)
            begin
                found_end = 1'b1;
            end
            else
            begin
                total += vec_mem[i][39:32];
                n_vec++;
            end
        end
        if (!found_end)
        begin
            abort_run("vector file holds no end marker");
        end
        cycle_limit = total * 4 + TIMEOUT_MARGIN;

        wait (!rrst && !wrst);
        for (int i = 0; i < n_vec; i++)
        begin
            run_vector(vec_mem[i]);
        end

        $display("sim passed");
        $finish;
    end

endmodule

// File: compile.f
+incdir+hw
hw/fifo_pkg.sv
hw/gray_sync.sv
hw/fifo_ctrl.sv
hw/fifo_ram.sv
hw/rd_data_fifo.sv
dv/tb_clk_gen.sv
dv/tb_rd_data_fifo.sv

// File: Bender.yml
package:
  name: rd_data_fifo

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/fifo_pkg.sv
      - hw/gray_sync.sv
      - hw/fifo_ctrl.sv
      - hw/fifo_ram.sv
      - hw/rd_data_fifo.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_rd_data_fifo.sv

// File: dv/rd_fifo_vectors.txt
// fields, hex: op _ count _ wfull _ rempty _ almost_full _ almost_empty _ wr_lvl _ rd_lvl
// op 0 idle, 1 write burst, 2 read burst, f end; flags and levels after settle
// after reset
0_04_0_1_0_1_00_00
// reads on empty fifo are dropped
2_03_0_1_0_1_00_00
// small fill and drain
1_05_0_0_0_0_05_05
2_03_0_0_0_1_02_02
2_02_0_1_0_1_00_00
// almost_empty edge
1_01_0_0_0_1_01_01
1_01_0_0_0_1_02_02
1_01_0_0_0_0_03_03
2_03_0_1_0_1_00_00
// overfill, only sixteen words kept
1_14_1_0_1_0_10_10
0_04_1_0_1_0_10_10
1_04_1_0_1_0_10_10
// almost_full edge
2_01_0_0_1_0_0f_0f
2_01_0_0_1_0_0e_0e
2_01_0_0_0_0_0d_0d
1_03_1_0_1_0_10_10
2_10_0_1_0_1_00_00
2_02_0_1_0_1_00_00
// mixed bursts across pointer wrap
1_09_0_0_0_0_09_09
2_04_0_0_0_0_05_05
1_07_0_0_0_0_0c_0c
2_0a_0_0_0_1_02_02
1_0d_0_0_1_0_0f_0f
2_0e_0_0_0_1_01_01
1_06_0_0_0_0_07_07
2_07_0_1_0_1_00_00
1_10_1_0_1_0_10_10
2_14_0_1_0_1_00_00
0_03_0_1_0_1_00_00
// end marker
f_00_0_0_0_0_00_00
